//--- bank_port.sv
`timescale 1ns/100ps
`default_nettype none

module bank_port #(
	parameter int READ_LATENCY = 2
) (
	input wire clock,
	input wire reset,
	input wire sram_pkg::bank_cmd_t [2:0] candidates,
	output sram_pkg::bank_cmd_t bank_cmd,
	output sram_pkg::client_t return_tag
);

	sram_pkg::bank_cmd_t picked;
	sram_pkg::client_t read_tag;

	// tag of each read in flight, oldest at the end
	sram_pkg::client_t tag_queue [READ_LATENCY];

	// fixed priority, entry 0 wins
	always_comb begin
		picked = sram_pkg::IDLE_CMD;
		for (int i = 2; i >= 0; i--) begin
			if (candidates[i].client != sram_pkg::CLIENT_NONE)
				picked = candidates[i];
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			bank_cmd <= sram_pkg::IDLE_CMD;
		else
			bank_cmd <= picked;
	end

	// only reads need their data routed back
	always_comb begin
		if (bank_cmd.we)
			read_tag = sram_pkg::CLIENT_NONE;
		else
			read_tag = bank_cmd.client;
	end

	// one stage per cycle of SRAM read latency
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < READ_LATENCY; i++)
				tag_queue[i] <= sram_pkg::CLIENT_NONE;
		end else begin
			tag_queue[0] <= read_tag;
			for (int i = 1; i < READ_LATENCY; i++)
				tag_queue[i] <= tag_queue[i - 1];
		end
	end

	// names the owner of the word on bank_read this cycle
	assign return_tag = tag_queue[READ_LATENCY - 1];

endmodule

`default_nettype wire

//--- buffer_rotation.sv
`timescale 1ns/100ps
`default_nettype none

module buffer_rotation (
	input wire clock,
	input wire reset,
	input wire frame_flag,
	output frame_pkg::role_map_t roles
);

	always_ff @(posedge clock) begin
		if (reset) begin
			// capture and filter start in bank 0 while next and display start in bank 1
			roles.capture.bank <= 1'b0;
			roles.capture.slot <= 2'd0;
			roles.filter.bank <= 1'b0;
			roles.filter.slot <= 2'd1;
			roles.next.bank <= 1'b1;
			roles.next.slot <= 2'd0;
			roles.display.bank <= 1'b1;
			roles.display.slot <= 2'd1;
		end else if (frame_flag) begin
			// the filtered buffer is captured into again and the displayed one gets filtered
			// while the newest capture waits as next
			roles.capture <= roles.filter;
			roles.filter <= roles.display;
			roles.next <= roles.capture;
			roles.display <= roles.next;
		end
	end

endmodule

`default_nettype wire

//--- frame_pkg.sv
`default_nettype none

package frame_pkg;

	// picture geometry
	localparam int unsigned LINE_PIXELS = 640;
	localparam int unsigned FRAME_LINES = 480;

	// two pixels share one SRAM word
	localparam int unsigned WORDS_PER_LINE = LINE_PIXELS / 2;
	localparam int unsigned SLOT_WORDS = WORDS_PER_LINE * FRAME_LINES;

	typedef logic [9:0] x_t;
	typedef logic [8:0] y_t;

	// slot within a bank, slot 3 maps to base 0
	typedef logic [1:0] slot_t;

	// where one frame buffer lives
	typedef struct packed {
		logic bank;
		slot_t slot;
	} placement_t;

	// one placement per buffer role
	typedef struct packed {
		placement_t capture;
		placement_t filter;
		placement_t next;
		placement_t display;
	} role_map_t;

	// client pixel request
	typedef struct packed {
		logic valid;
		x_t x;
		y_t y;
	} pixel_req_t;

endpackage

`default_nettype wire

//--- frame_store_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module frame_store_ctrl #(
	parameter int READ_LATENCY = 2
) (
	input wire clock,
	input wire reset,
	input wire frame_flag,
	input wire frame_pkg::pixel_req_t capture_req,
	input wire sram_pkg::word_t capture_pixel,
	input wire frame_pkg::pixel_req_t display_req,
	input wire frame_pkg::pixel_req_t filter_req,
	input wire filter_wr,
	input wire sram_pkg::word_t filter_pixel_write,
	output sram_pkg::bank_cmd_t bank_cmd [sram_pkg::BANKS],
	input wire sram_pkg::word_t bank_read [sram_pkg::BANKS],
	output logic done_capture,
	output logic done_display,
	output logic done_filter,
	output sram_pkg::word_t display_pixel,
	output sram_pkg::word_t filter_pixel_read
);

	frame_pkg::role_map_t roles;
	sram_pkg::bank_cmd_t [2:0] candidates [sram_pkg::BANKS];
	sram_pkg::client_t issued_client [sram_pkg::BANKS];
	sram_pkg::client_t return_tag [sram_pkg::BANKS];

	buffer_rotation rotation (
		.clock(clock),
		.reset(reset),
		.frame_flag(frame_flag),
		.roles(roles)
	);

	request_router router (
		.roles(roles),
		.capture_req(capture_req),
		.capture_pixel(capture_pixel),
		.display_req(display_req),
		.filter_req(filter_req),
		.filter_wr(filter_wr),
		.filter_pixel_write(filter_pixel_write),
		.candidates(candidates)
	);

	// one port per SRAM bank
	for (genvar b = 0; b < sram_pkg::BANKS; b++) begin : g_bank
		bank_port #(
			.READ_LATENCY(READ_LATENCY)
		) port (
			.clock(clock),
			.reset(reset),
			.candidates(candidates[b]),
			.bank_cmd(bank_cmd[b]),
			.return_tag(return_tag[b])
		);

		assign issued_client[b] = bank_cmd[b].client;
	end

	read_return returns (
		.clock(clock),
		.reset(reset),
		.issued_client(issued_client),
		.return_tag(return_tag),
		.bank_read(bank_read),
		.done_capture(done_capture),
		.done_display(done_display),
		.done_filter(done_filter),
		.display_pixel(display_pixel),
		.filter_pixel_read(filter_pixel_read)
	);

endmodule

`default_nettype wire

//--- frame_store_golden.txt
# op with x y data(hex) bank addr hold; op F frame pulse, C capture write, D display read,
# W filter write, R filter read; with 1 joins the next line in one cycle; hold is cycles to done
C 0 10 3 abcde0123 0 965 1
C 0 639 479 f0f0f0f0f 0 153599 1
W 0 20 2 123456789 0 154250 1
R 0 21 2 123456789 0 154250 1
D 0 4 1 000000000 1 153922 1
C 1 100 10 00000aaaa 0 3250 1
W 0 2 0 55555bbbb 0 153601 2
F 0 0 0 000000000 0 0 0
C 1 6 0 111111111 0 153603 1
W 0 8 0 222222222 1 153604 1
R 0 9 0 222222222 1 153604 1
D 0 0 2 000000000 1 640 1
F 0 0 0 000000000 0 0 0
D 0 10 3 abcde0123 0 965 1
C 1 0 1 333333333 1 153920 1
D 0 639 479 f0f0f0f0f 0 153599 1
F 0 0 0 000000000 0 0 0
D 1 40 0 000000000 0 153620 1
R 0 10 3 abcde0123 0 965 2
F 0 0 0 000000000 0 0 0
C 0 2 0 0000000ff 0 1 1
D 0 4 1 000000000 1 153922 1
R 0 2 0 55555bbbb 0 153601 1

//--- frame_store_tb.sv
`timescale 1ns/100ps
`default_nettype none

module frame_store_tb;

	localparam int READ_LATENCY = 2;
	localparam int WAIT_LIMIT = 20;
	localparam int RESET_LIMIT = 10;

	logic clock;
	logic reset;
	logic frame_flag;
	frame_pkg::pixel_req_t capture_req;
	sram_pkg::word_t capture_pixel;
	frame_pkg::pixel_req_t display_req;
	frame_pkg::pixel_req_t filter_req;
	logic filter_wr;
	sram_pkg::word_t filter_pixel_write;
	sram_pkg::bank_cmd_t bank_cmd [sram_pkg::BANKS];
	sram_pkg::word_t bank_read [sram_pkg::BANKS];
	logic done_capture;
	logic done_display;
	logic done_filter;
	sram_pkg::word_t display_pixel;
	sram_pkg::word_t filter_pixel_read;

	// sparse SRAM contents with the bank number above the address
	sram_pkg::word_t sram_mem [int];
	sram_pkg::word_t read_pipe [sram_pkg::BANKS][READ_LATENCY];
	logic [15:0] lfsr_state;

	// one request slot per client in the order capture display filter
	logic group_active [3];
	logic group_write [3];
	frame_pkg::x_t group_x [3];
	frame_pkg::y_t group_y [3];
	sram_pkg::word_t group_data [3];
	logic group_bank [3];
	sram_pkg::addr_t group_addr [3];
	int group_hold [3];

	tb_clock_gen #(
		.PERIOD_NS(40),
		.RESET_CYCLES(2)
	) clock_gen (
		.clock(clock),
		.reset(reset)
	);

	frame_store_ctrl #(
		.READ_LATENCY(READ_LATENCY)
	) UUT (
		.clock(clock),
		.reset(reset),
		.frame_flag(frame_flag),
		.capture_req(capture_req),
		.capture_pixel(capture_pixel),
		.display_req(display_req),
		.filter_req(filter_req),
		.filter_wr(filter_wr),
		.filter_pixel_write(filter_pixel_write),
		.bank_cmd(bank_cmd),
		.bank_read(bank_read),
		.done_capture(done_capture),
		.done_display(done_display),
		.done_filter(done_filter),
		.display_pixel(display_pixel),
		.filter_pixel_read(filter_pixel_read)
	);

	// SRAM model writes on the edge and returns read data READ_LATENCY edges later
	always @(posedge clock) begin
		int key;
		for (int b = 0; b < sram_pkg::BANKS; b++) begin
			key = (b << 19) + int'(bank_cmd[b].addr);
			if (sram_mem.exists(key))
				read_pipe[b][0] <= sram_mem[key];
			else
				read_pipe[b][0] <= '0;
			for (int i = 1; i < READ_LATENCY; i++)
				read_pipe[b][i] <= read_pipe[b][i - 1];
			if (bank_cmd[b].we && bank_cmd[b].client != sram_pkg::CLIENT_NONE)
				sram_mem[key] = bank_cmd[b].data;
		end
	end

	always_comb begin
		for (int b = 0; b < sram_pkg::BANKS; b++)
			bank_read[b] = read_pipe[b][READ_LATENCY - 1];
	end

	task automatic fail_now(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_cmd(input string name, input sram_pkg::bank_cmd_t actual,
			input sram_pkg::bank_cmd_t expected);
		if (actual !== expected)
			fail_now($sformatf("error at %0t: %s expected %h got %h",
				$time, name, expected, actual));
	endtask

	task automatic check_word(input string name, input sram_pkg::word_t actual,
			input sram_pkg::word_t expected);
		if (actual !== expected)
			fail_now($sformatf("error at %0t: %s expected %h got %h",
				$time, name, expected, actual));
	endtask

	task automatic check_done(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			fail_now($sformatf("error at %0t: %s expected %b got %b",
				$time, name, expected, actual));
	endtask

	// Galois LFSR with taps at 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		else
			return state >> 1;
	endfunction

	// 0 to 3 idle cycles between operations
	task automatic random_gap();
		int gap;
		gap = 0;
		for (int i = 0; i < 2; i++) begin
			gap = (gap << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		repeat (gap) @(posedge clock);
	endtask

	function automatic string client_label(input int c);
		case (c)
			0: return "capture";
			1: return "display";
			default: return "filter";
		endcase
	endfunction

	function automatic logic done_of(input int c);
		case (c)
			0: return done_capture;
			1: return done_display;
			default: return done_filter;
		endcase
	endfunction

	// command the bank should carry when this client wins
	function automatic sram_pkg::bank_cmd_t issued_cmd(input int c);
		sram_pkg::bank_cmd_t cmd;
		cmd.addr = group_addr[c];
		cmd.data = group_write[c] ? group_data[c] : '0;
		cmd.we = group_write[c];
		case (c)
			0: cmd.client = sram_pkg::CLIENT_CAPTURE;
			1: cmd.client = sram_pkg::CLIENT_DISPLAY;
			default: cmd.client = sram_pkg::CLIENT_FILTER;
		endcase
		return cmd;
	endfunction

	task automatic add_to_group(input logic [7:0] op, input int x, input int y,
			input sram_pkg::word_t data, input int bank, input int addr, input int hold);
		int c;
		case (op)
			"C": c = 0;
			"D": c = 1;
			"W", "R": c = 2;
			default: fail_now($sformatf("unknown operation %s in the golden file", op));
		endcase
		if (group_active[c])
			fail_now("two requests for one client in the same golden file group");
		group_active[c] = 1'b1;
		group_write[c] = (op == "C" || op == "W");
		group_x[c] = frame_pkg::x_t'(x);
		group_y[c] = frame_pkg::y_t'(y);
		group_data[c] = data;
		group_bank[c] = bank[0];
		group_addr[c] = sram_pkg::addr_t'(addr);
		group_hold[c] = hold;
	endtask

	task automatic drive_requests();
		if (group_active[0]) begin
			capture_req <= {1'b1, group_x[0], group_y[0]};
			capture_pixel <= group_data[0];
		end
		if (group_active[1])
			display_req <= {1'b1, group_x[1], group_y[1]};
		if (group_active[2]) begin
			filter_req <= {1'b1, group_x[2], group_y[2]};
			filter_wr <= group_write[2];
			filter_pixel_write <= group_write[2] ? group_data[2] : '0;
		end
	endtask

	// a client drops its request after the edge that issues it
	task automatic release_requests(input int cycles);
		if (group_active[0] && group_hold[0] == cycles) begin
			capture_req <= '0;
			capture_pixel <= '0;
		end
		if (group_active[1] && group_hold[1] == cycles)
			display_req <= '0;
		if (group_active[2] && group_hold[2] == cycles) begin
			filter_req <= '0;
			filter_wr <= 1'b0;
			filter_pixel_write <= '0;
		end
	endtask

	task automatic run_group();
		int cycles;
		int done_at [3];
		logic pixel_checked [3];
		logic finished;
		sram_pkg::bank_cmd_t expected [sram_pkg::BANKS];
		sram_pkg::word_t pixel;
		cycles = 0;
		finished = 1'b0;
		for (int c = 0; c < 3; c++) begin
			done_at[c] = 0;
			pixel_checked[c] = 1'b0;
		end
		@(posedge clock);
		drive_requests();
		while (!finished) begin
			@(posedge clock);
			cycles++;
			release_requests(cycles);
			@(negedge clock);
			for (int b = 0; b < sram_pkg::BANKS; b++)
				expected[b] = '0;
			for (int c = 0; c < 3; c++) begin
				if (group_active[c] && group_hold[c] == cycles)
					expected[group_bank[c]] = issued_cmd(c);
			end
			for (int b = 0; b < sram_pkg::BANKS; b++)
				check_cmd($sformatf("bank_cmd[%0d]", b), bank_cmd[b], expected[b]);
			finished = 1'b1;
			for (int c = 0; c < 3; c++) begin
				check_done({"done_", client_label(c)}, done_of(c),
					group_active[c] && group_hold[c] == cycles);
				if (group_active[c]) begin
					if (done_of(c) && done_at[c] == 0)
						done_at[c] = cycles;
					// read data lands READ_LATENCY + 1 cycles after done and then holds
					if (!group_write[c] && !pixel_checked[c] && done_at[c] != 0
							&& cycles >= done_at[c] + READ_LATENCY + 1) begin
						if (c == 1) begin
							pixel = display_pixel;
							check_word("display_pixel", pixel, group_data[c]);
						end else begin
							pixel = filter_pixel_read;
							check_word("filter_pixel_read", pixel, group_data[c]);
						end
						if (cycles == done_at[c] + READ_LATENCY + 2)
							pixel_checked[c] = 1'b1;
					end
					if (done_at[c] == 0 || cycles <= done_at[c])
						finished = 1'b0;
					if (!group_write[c] && !pixel_checked[c])
						finished = 1'b0;
				end
			end
			if (!finished && cycles >= WAIT_LIMIT)
				fail_now($sformatf("timeout: a request was not completed within %0d cycles",
					WAIT_LIMIT));
		end
		for (int c = 0; c < 3; c++)
			group_active[c] = 1'b0;
	endtask

	task automatic pulse_frame();
		@(posedge clock);
		frame_flag <= 1'b1;
		@(posedge clock);
		frame_flag <= 1'b0;
	endtask

	initial begin
		int fd;
		int fields;
		int op_count;
		int wait_cycles;
		int with_next;
		int x;
		int y;
		int bank;
		int addr;
		int hold;
		logic [7:0] op;
		sram_pkg::word_t data;
		string line;
		lfsr_state = 16'd96;
		frame_flag = 1'b0;
		capture_req = '0;
		capture_pixel = '0;
		display_req = '0;
		filter_req = '0;
		filter_wr = 1'b0;
		filter_pixel_write = '0;
		for (int b = 0; b < sram_pkg::BANKS; b++) begin
			for (int i = 0; i < READ_LATENCY; i++)
				read_pipe[b][i] = '0;
		end
		for (int c = 0; c < 3; c++)
			group_active[c] = 1'b0;
		op_count = 0;
		wait_cycles = 0;
		@(negedge clock);
		while (reset) begin
			wait_cycles++;
			if (wait_cycles > RESET_LIMIT)
				fail_now("reset was never released");
			@(negedge clock);
		end
		check_done("done_capture", done_capture, 1'b0);
		check_done("done_display", done_display, 1'b0);
		check_done("done_filter", done_filter, 1'b0);
		for (int b = 0; b < sram_pkg::BANKS; b++)
			check_cmd($sformatf("bank_cmd[%0d]", b), bank_cmd[b], '0);
		fd = $fopen("frame_store_golden.txt", "r");
		if (fd == 0)
			fail_now("the golden file frame_store_golden.txt could not be opened");
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%c %d %d %d %h %d %d %d",
				op, with_next, x, y, data, bank, addr, hold);
			if (fields != 8)
				continue;
			if (op == "F") begin
				pulse_frame();
				op_count++;
			end else begin
				add_to_group(op, x, y, data, bank, addr, hold);
				// lines marked with 1 start in the same cycle as the next one
				if (with_next == 0) begin
					run_group();
					random_gap();
					op_count++;
				end
			end
		end
		$fclose(fd);
		if (op_count == 0) begin
			fail_now("the golden file held no operations");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- list.f
frame_pkg.sv
sram_pkg.sv
buffer_rotation.sv
request_router.sv
bank_port.sv
read_return.sv
frame_store_ctrl.sv
tb_clock_gen.sv
frame_store_tb.sv

//--- read_return.sv
`timescale 1ns/100ps
`default_nettype none

module read_return (
	input wire clock,
	input wire reset,
	input wire sram_pkg::client_t issued_client [sram_pkg::BANKS],
	input wire sram_pkg::client_t return_tag [sram_pkg::BANKS],
	input wire sram_pkg::word_t bank_read [sram_pkg::BANKS],
	output logic done_capture,
	output logic done_display,
	output logic done_filter,
	output sram_pkg::word_t display_pixel,
	output sram_pkg::word_t filter_pixel_read
);

	// a client is done in the cycle its command sits on either bank
	always_comb begin
		done_capture = 1'b0;
		done_display = 1'b0;
		done_filter = 1'b0;
		for (int b = 0; b < sram_pkg::BANKS; b++) begin
			if (issued_client[b] == sram_pkg::CLIENT_CAPTURE)
				done_capture = 1'b1;
			if (issued_client[b] == sram_pkg::CLIENT_DISPLAY)
				done_display = 1'b1;
			if (issued_client[b] == sram_pkg::CLIENT_FILTER)
				done_filter = 1'b1;
		end
	end

	// load from the bank whose tag names the client, else hold
	always_ff @(posedge clock) begin
		if (reset) begin
			display_pixel <= '0;
			filter_pixel_read <= '0;
		end else begin
			// bank 0 takes precedence, though a client never reads both at once
			for (int b = sram_pkg::BANKS - 1; b >= 0; b--) begin
				if (return_tag[b] == sram_pkg::CLIENT_DISPLAY)
					display_pixel <= bank_read[b];
				if (return_tag[b] == sram_pkg::CLIENT_FILTER)
					filter_pixel_read <= bank_read[b];
			end
		end
	end

endmodule

`default_nettype wire

//--- request_router.sv
`timescale 1ns/100ps
`default_nettype none

module request_router (
	input wire frame_pkg::role_map_t roles,
	input wire frame_pkg::pixel_req_t capture_req,
	input wire sram_pkg::word_t capture_pixel,
	input wire frame_pkg::pixel_req_t display_req,
	input wire frame_pkg::pixel_req_t filter_req,
	input wire filter_wr,
	input wire sram_pkg::word_t filter_pixel_write,
	output sram_pkg::bank_cmd_t [2:0] candidates [sram_pkg::BANKS]
);

	sram_pkg::bank_cmd_t capture_cmd;
	sram_pkg::bank_cmd_t display_cmd;
	sram_pkg::bank_cmd_t filter_cmd;

	// slot base + line offset + half the column
	function automatic sram_pkg::addr_t pixel_addr(
		input frame_pkg::placement_t place,
		input frame_pkg::x_t x,
		input frame_pkg::y_t y
	);
		sram_pkg::addr_t base;
		sram_pkg::addr_t line;
		case (place.slot)
			2'd1: base = sram_pkg::addr_t'(frame_pkg::SLOT_WORDS);
			2'd2: base = sram_pkg::addr_t'(2 * frame_pkg::SLOT_WORDS);
			default: base = '0;
		endcase
		// WORDS_PER_LINE is 320, done as 256 + 64
		line = (sram_pkg::addr_t'(y) << 8) + (sram_pkg::addr_t'(y) << 6);
		return base + line + sram_pkg::addr_t'(x >> 1);
	endfunction

	always_comb begin
		capture_cmd.addr = pixel_addr(roles.capture, capture_req.x, capture_req.y);
		capture_cmd.data = capture_pixel;
		capture_cmd.we = 1'b1;
		capture_cmd.client = sram_pkg::CLIENT_CAPTURE;

		display_cmd.addr = pixel_addr(roles.display, display_req.x, display_req.y);
		display_cmd.data = '0;
		display_cmd.we = 1'b0;
		display_cmd.client = sram_pkg::CLIENT_DISPLAY;

		filter_cmd.addr = pixel_addr(roles.filter, filter_req.x, filter_req.y);
		filter_cmd.data = filter_pixel_write;
		filter_cmd.we = filter_wr;
		filter_cmd.client = sram_pkg::CLIENT_FILTER;
	end

	// entries are in priority order: capture, display, filter
	always_comb begin
		for (int b = 0; b < sram_pkg::BANKS; b++) begin
			candidates[b][0] = sram_pkg::IDLE_CMD;
			candidates[b][1] = sram_pkg::IDLE_CMD;
			candidates[b][2] = sram_pkg::IDLE_CMD;
			if (capture_req.valid && roles.capture.bank == b[0])
				candidates[b][0] = capture_cmd;
			if (display_req.valid && roles.display.bank == b[0])
				candidates[b][1] = display_cmd;
			if (filter_req.valid && roles.filter.bank == b[0])
				candidates[b][2] = filter_cmd;
		end
	end

endmodule

`default_nettype wire

//--- sram_pkg.sv
`default_nettype none

package sram_pkg;

	localparam int unsigned BANKS = 2;

	// SRAM data word and word address
	typedef logic [35:0] word_t;
	typedef logic [18:0] addr_t;

	// which client a command belongs to
	typedef enum logic [1:0] {
		CLIENT_NONE = 2'd0,
		CLIENT_CAPTURE = 2'd1,
		CLIENT_DISPLAY = 2'd2,
		CLIENT_FILTER = 2'd3
	} client_t;

	// one bank command, for candidates and issued commands alike
	typedef struct packed {
		addr_t addr;
		word_t data;
		logic we;
		client_t client;
	} bank_cmd_t;

	// no access this cycle
	localparam bank_cmd_t IDLE_CMD = '{
		addr: '0,
		data: '0,
		we: 1'b0,
		client: CLIENT_NONE
	};

endpackage

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// reset covers the first rising edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
